// ==== Bender.yml ====
package:
  name: energy_monitor

sources:
  # RTL, package first
  - files:
      - hw/ising_pkg.sv
      - hw/bp_pipe.sv
      - hw/logic_ctrl.sv
      - hw/counter_ctrl.sv
      - hw/partial_energy_calc.sv
      - hw/accumulator.sv
      - hw/energy_monitor.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/energy_monitor_properties.sv
      - sim/tb_energy_monitor.sv

// ==== hw/accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module accumulator import ising_pkg::*; (
    input  wire logic                               clk_i,
    input  wire logic                               arst_n_i,
    input  wire logic                               en_i,
    input  wire logic                               clear_i,
    input  wire logic                               valid_i,
    input  wire logic                               last_i,
    input  wire logic signed [LOCAL_ENERGY_BIT-1:0] data_i,
    output logic signed      [ENERGY_TOTAL_BIT-1:0] accum_o,
    output logic                                    overflow_o,
    output logic                                    valid_o
);

    logic signed [ENERGY_TOTAL_BIT-1:0] accum_q;
    logic signed [ENERGY_TOTAL_BIT-1:0] addend;
    logic signed [ENERGY_TOTAL_BIT-1:0] sum;
    logic                               ovf;
    logic                               ovf_q;
    logic                               done_q;

    assign addend = data_i; // sign extension
    assign sum = accum_q + addend;
    // operands agree in sign but the result does not
    assign ovf = (accum_q[ENERGY_TOTAL_BIT-1] == addend[ENERGY_TOTAL_BIT-1])
              && (sum[ENERGY_TOTAL_BIT-1] != accum_q[ENERGY_TOTAL_BIT-1]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            accum_q <= '0;
            ovf_q <= 1'b0;
            done_q <= 1'b0;
        end else if (en_i) begin
            if (clear_i) begin
                accum_q <= '0;
                ovf_q <= 1'b0;
                done_q <= 1'b0;
            end else if (valid_i) begin
                accum_q <= sum;
                ovf_q <= ovf_q || ovf; // sticky until clear
                done_q <= last_i;
            end else begin
                done_q <= 1'b0;
            end
        end
    end

    assign accum_o = accum_q;
    assign overflow_o = ovf_q;
    assign valid_o = done_q;

endmodule

`default_nettype wire

// ==== hw/bp_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_pipe #(
    parameter int DATAW = 8,
    parameter int PIPES = 1
) (
    input  wire logic             clk_i,
    input  wire logic             arst_n_i,
    input  wire logic [DATAW-1:0] data_i,
    input  wire logic             valid_i,
    output logic                  ready_o,
    output logic      [DATAW-1:0] data_o,
    output logic                  valid_o,
    input  wire logic             ready_i
);

    // index 0 is the upstream side, index PIPES the downstream side
    wire [PIPES:0] vld;
    wire [PIPES:0] rdy;
    wire [DATAW-1:0] dat [PIPES+1];

    assign vld[0] = valid_i;
    assign dat[0] = data_i;
    assign rdy[PIPES] = ready_i;

    for (genvar k = 0; k < PIPES; k++) begin : g_stage
        logic             v_q;
        logic [DATAW-1:0] d_q;

        // stage takes new data when empty or when it drains this cycle
        assign rdy[k] = !v_q || rdy[k+1];

        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                v_q <= 1'b0;
            end else if (rdy[k]) begin
                v_q <= vld[k];
            end
        end

        always_ff @(posedge clk_i) begin
            if (rdy[k] && vld[k]) begin
                d_q <= dat[k];
            end
        end

        assign vld[k+1] = v_q;
        assign dat[k+1] = d_q;
    end

    assign ready_o = rdy[0];
    assign valid_o = vld[PIPES];
    assign data_o = dat[PIPES];

endmodule

`default_nettype wire

// ==== hw/counter_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module counter_ctrl import ising_pkg::*; (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic                   en_i,
    input  wire logic                   config_valid_i,
    input  wire logic                   config_ready_i,
    input  wire logic [SPINIDX_BIT-1:0] config_counter_i,
    input  wire logic                   recount_en_i,
    input  wire logic                   step_en_i,
    output logic      [SPINIDX_BIT-1:0] q_o,
    output logic                        counter_ready_o,
    output logic                        last_o
);

    logic [SPINIDX_BIT-1:0] last_idx_q; // index of the final row in a frame
    logic [SPINIDX_BIT-1:0] q_q;
    logic                   busy_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_idx_q <= '0;
            q_q <= '0;
            busy_q <= 1'b0;
        end else if (en_i) begin
            if (config_valid_i && config_ready_i) begin
                last_idx_q <= config_counter_i;
            end
            if (recount_en_i) begin
                q_q <= '0;
                busy_q <= 1'b1;
            end else if (step_en_i) begin
                q_q <= q_q + 1'b1; // wraps after the top index
                if (q_q == last_idx_q) busy_q <= 1'b0;
            end
        end
    end

    assign q_o = q_q;
    assign counter_ready_o = busy_q;
    assign last_o = busy_q && (q_q == last_idx_q); // current row closes the frame

endmodule

`default_nettype wire

// ==== hw/energy_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module energy_monitor import ising_pkg::*; (
    input  wire logic                               clk_i,
    input  wire logic                               arst_n_i,
    input  wire logic                               en_i,

    input  wire logic                               config_valid_i,
    input  wire logic        [SPINIDX_BIT-1:0]      config_counter_i,
    output logic                                    config_ready_o,

    input  wire logic                               spin_valid_i,
    input  wire logic        [DATASPIN-1:0]         spin_i,
    output logic                                    spin_ready_o,

    input  wire logic                               weight_valid_i,
    input  wire logic        [DATAJ-1:0]            weight_i,
    input  wire logic signed [BITH-1:0]             hbias_i,
    input  wire logic        [SCALING_BIT-1:0]      hscaling_i,
    output logic                                    weight_ready_o,

    output logic                                    energy_valid_o,
    output logic signed      [ENERGY_TOTAL_BIT-1:0] energy_o,
    input  wire logic                               energy_ready_i,

    input  wire logic                               debug_en_i,
    output logic                                    accum_overflow_o
);

    // pipe outputs
    logic                      config_valid_p;
    logic [SPINIDX_BIT-1:0]    config_counter_p;
    logic                      config_ready_p;
    logic                      spin_valid_p;
    logic [DATASPIN-1:0]       spin_p;
    logic                      spin_ready_p;
    logic                      weight_valid_p;
    logic [WEIGHT_BUS_BIT-1:0] weight_bus_p;
    logic                      weight_ready_p;

    logic [DATAJ-1:0]       weight_p;
    logic signed [BITH-1:0] hbias_p;
    logic [SCALING_BIT-1:0] hscaling_p;

    logic                               spin_hs;
    logic                               weight_hs;
    logic                               energy_hs;
    logic [SPINIDX_BIT-1:0]             counter_q;
    logic                               counter_ready;
    logic                               counter_last;
    logic                               cmpt_done;
    logic                               accum_ovf;
    logic signed [LOCAL_ENERGY_BIT-1:0] local_energy;

    assign spin_hs = spin_valid_p && spin_ready_p;
    assign weight_hs = weight_valid_p && weight_ready_p;
    assign energy_hs = energy_valid_o && energy_ready_i;

    assign weight_p = weight_bus_p[WEIGHT_BUS_BIT-1 -: DATAJ];
    assign hbias_p = weight_bus_p[SCALING_BIT +: BITH];
    assign hscaling_p = weight_bus_p[SCALING_BIT-1:0];

    bp_pipe #(.DATAW(SPINIDX_BIT), .PIPES(PIPES)) u_pipe_config (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .data_i   (config_counter_i),
        .valid_i  (config_valid_i),
        .ready_o  (config_ready_o),
        .data_o   (config_counter_p),
        .valid_o  (config_valid_p),
        .ready_i  (config_ready_p)
    );

    bp_pipe #(.DATAW(DATASPIN), .PIPES(PIPES)) u_pipe_spin (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .data_i   (spin_i),
        .valid_i  (spin_valid_i),
        .ready_o  (spin_ready_o),
        .data_o   (spin_p),
        .valid_o  (spin_valid_p),
        .ready_i  (spin_ready_p)
    );

    bp_pipe #(.DATAW(WEIGHT_BUS_BIT), .PIPES(PIPES)) u_pipe_weight (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .data_i   ({weight_i, hbias_i, hscaling_i}),
        .valid_i  (weight_valid_i),
        .ready_o  (weight_ready_o),
        .data_o   (weight_bus_p),
        .valid_o  (weight_valid_p),
        .ready_i  (weight_ready_p)
    );

    logic_ctrl u_logic_ctrl (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .en_i            (en_i),
        .config_valid_i  (config_valid_p),
        .config_ready_o  (config_ready_p),
        .spin_valid_i    (spin_valid_p),
        .spin_ready_o    (spin_ready_p),
        .weight_valid_i  (weight_valid_p),
        .weight_ready_o  (weight_ready_p),
        .counter_ready_i (counter_ready),
        .cmpt_done_i     (cmpt_done),
        .energy_valid_o  (energy_valid_o),
        .energy_ready_i  (energy_ready_i)
    );

    counter_ctrl u_counter_ctrl (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .en_i             (en_i),
        .config_valid_i   (config_valid_p),
        .config_ready_i   (config_ready_p),
        .config_counter_i (config_counter_p),
        .recount_en_i     (spin_hs),
        .step_en_i        (weight_hs),
        .q_o              (counter_q),
        .counter_ready_o  (counter_ready),
        .last_o           (counter_last)
    );

    partial_energy_calc u_partial_energy_calc (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .en_i        (en_i),
        .spin_load_i (spin_hs),
        .spin_i      (spin_p),
        .idx_i       (counter_q),
        .weight_i    (weight_p),
        .hbias_i     (hbias_p),
        .hscaling_i  (hscaling_p),
        .energy_o    (local_energy)
    );

    accumulator u_accumulator (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .en_i       (en_i),
        .clear_i    (energy_hs), // accepted result starts a fresh sum
        .valid_i    (weight_hs),
        .last_i     (counter_last),
        .data_i     (local_energy),
        .accum_o    (energy_o),
        .overflow_o (accum_ovf),
        .valid_o    (cmpt_done)
    );

    assign accum_overflow_o = accum_ovf && debug_en_i;

endmodule

`default_nettype wire

// ==== hw/ising_pkg.sv ====
`default_nettype none

package ising_pkg;

    // problem size
    localparam int DATASPIN = 16;
    localparam int BITJ = 4;
    localparam int BITH = 4;
    localparam int SCALING_BIT = 5;
    localparam int DATAJ = DATASPIN * BITJ;
    localparam int SPINIDX_BIT = $clog2(DATASPIN);

    // arithmetic widths
    localparam int LOCAL_ENERGY_BIT = 16;
    localparam int ENERGY_TOTAL_BIT = 32;

    // register stages per input channel
    localparam int PIPES = 1;

    // weight row, bias and scaling travel as one word
    localparam int WEIGHT_BUS_BIT = DATAJ + BITH + SCALING_BIT;

    // frame sequencer states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT_SPIN = 2'd1;
    localparam logic [1:0] ST_RUN = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

endpackage

`default_nettype wire

// ==== hw/logic_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module logic_ctrl import ising_pkg::*; (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic en_i,
    input  wire logic config_valid_i,
    output logic      config_ready_o,
    input  wire logic spin_valid_i,
    output logic      spin_ready_o,
    input  wire logic weight_valid_i,
    output logic      weight_ready_o,
    input  wire logic counter_ready_i,
    input  wire logic cmpt_done_i,
    output logic      energy_valid_o,
    input  wire logic energy_ready_i
);

    logic [1:0] state_q;
    logic [1:0] state_d;

    // one input channel open at a time, all closed while disabled
    assign config_ready_o = en_i && (state_q == ST_IDLE);
    assign spin_ready_o = en_i && (state_q == ST_WAIT_SPIN);
    assign weight_ready_o = en_i && (state_q == ST_RUN) && counter_ready_i;
    assign energy_valid_o = en_i && (state_q == ST_DONE); // no handshake while frozen

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (config_valid_i && config_ready_o) state_d = ST_WAIT_SPIN;
            end
            ST_WAIT_SPIN: begin
                if (spin_valid_i && spin_ready_o) state_d = ST_RUN;
            end
            ST_RUN: begin
                // weight handshakes are counted outside, wait for the sum
                if (cmpt_done_i) state_d = ST_DONE;
            end
            default: begin
                // config is kept, next frame only needs a spin vector
                if (energy_valid_o && energy_ready_i) state_d = ST_WAIT_SPIN;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else if (en_i) begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/partial_energy_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module partial_energy_calc import ising_pkg::*; (
    input  wire logic                               clk_i,
    input  wire logic                               arst_n_i,
    input  wire logic                               en_i,
    input  wire logic                               spin_load_i,
    input  wire logic        [DATASPIN-1:0]         spin_i,
    input  wire logic        [SPINIDX_BIT-1:0]      idx_i,
    input  wire logic        [DATAJ-1:0]            weight_i,
    input  wire logic signed [BITH-1:0]             hbias_i,
    input  wire logic        [SCALING_BIT-1:0]      hscaling_i,
    output logic signed      [LOCAL_ENERGY_BIT-1:0] energy_o
);

    logic [DATASPIN-1:0] spin_q;
    logic                cur_spin;

    logic signed [BITJ-1:0]             w;
    logic signed [LOCAL_ENERGY_BIT-1:0] sum_w;
    logic signed [LOCAL_ENERGY_BIT-1:0] h_term;
    logic signed [LOCAL_ENERGY_BIT-1:0] field;

    // spin vector cache, held for the whole frame
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_q <= '0;
        end else if (en_i && spin_load_i) begin
            spin_q <= spin_i;
        end
    end

    assign cur_spin = spin_q[idx_i];

    always_comb begin
        sum_w = '0;
        w = '0;
        for (int j = 0; j < DATASPIN; j++) begin
            w = weight_i[j*BITJ +: BITJ];
            // spin bit 0 stands for -1
            if (spin_q[j]) sum_w = sum_w + w;
            else           sum_w = sum_w - w;
        end
    end

    // scaling is unsigned, zero-extend before the signed multiply
    assign h_term = hbias_i * $signed({1'b0, hscaling_i});
    assign field = sum_w + h_term;
    assign energy_o = cur_spin ? field : -field;

endmodule

`default_nettype wire

// ==== sim/energy_monitor_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module energy_monitor_properties import ising_pkg::*; (
    input wire logic                        clk_i,
    input wire logic                        arst_n_i,
    input wire logic                        en_i,
    input wire logic                        energy_valid_i,
    input wire logic                        energy_ready_i,
    input wire logic [ENERGY_TOTAL_BIT-1:0] energy_i,
    input wire logic                        spin_open_i, // spin ready behind the pipe
    input wire logic                        rows_left_i, // weight rows of the frame still due
    input wire logic                        overflow_i
);

    int fail_count = 0;

    // a stalled result stays offered unless the monitor is frozen
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        energy_valid_i && !energy_ready_i |=> energy_valid_i || !en_i)
        else begin
            fail_count++;
            $error("energy_valid_o dropped while energy_ready_i was low");
        end

    a_data_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        energy_valid_i && !energy_ready_i |=> $stable(energy_i))
        else begin
            fail_count++;
            $error("energy_o changed while the result was stalled");
        end

    // a new spin vector must not cut into a frame that still expects rows
    a_no_spin_mid_frame: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(spin_open_i && rows_left_i))
        else begin
            fail_count++;
            $error("spin channel open while weight rows of the frame remain");
        end

    a_reset_quiet: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !energy_valid_i && !overflow_i)
        else begin
            fail_count++;
            $error("energy_valid_o or overflow flag high right after reset");
        end

endmodule

`default_nettype wire

// ==== sim/tb_energy_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_energy_monitor import ising_pkg::*; ();

    localparam int NUM_TESTS = 9;

    typedef struct packed {
        logic [SPINIDX_BIT-1:0] last_idx;
        logic [DATASPIN-1:0]    spins;
        logic [7:0]             stall;  // cycles with energy_ready held low
        logic                   en_gap; // en dropped mid-frame
        logic                   debug_en;
        logic                   max_w;  // weights and h term at full scale
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{4'd15, 16'hb36d, 8'd0, 1'b0, 1'b0, 1'b0}, // full frame
        '{4'd0,  16'h0001, 8'd0, 1'b0, 1'b0, 1'b0}, // single row
        '{4'd5,  16'h00a5, 8'd0, 1'b0, 1'b0, 1'b0},
        '{4'd5,  16'h3c0f, 8'd7, 1'b0, 1'b0, 1'b0}, // held result
        '{4'd5,  16'hffff, 8'd2, 1'b0, 1'b0, 1'b0}, // stored config reused
        '{4'd5,  16'h0000, 8'd0, 1'b0, 1'b0, 1'b0},
        '{4'd15, 16'h5a5a, 8'd3, 1'b1, 1'b0, 1'b0}, // en gap
        '{4'd15, 16'h8001, 8'd0, 1'b0, 1'b1, 1'b1},
        '{4'd15, 16'h7ffe, 8'd1, 1'b0, 1'b0, 1'b1}
    };

    logic                               clk;
    logic                               arst_n;
    logic                               en;
    logic                               config_valid;
    logic        [SPINIDX_BIT-1:0]      config_counter;
    logic                               config_ready;
    logic                               spin_valid;
    logic        [DATASPIN-1:0]         spin;
    logic                               spin_ready;
    logic                               weight_valid;
    logic        [DATAJ-1:0]            weight;
    logic signed [BITH-1:0]             hbias;
    logic        [SCALING_BIT-1:0]      hscaling;
    logic                               weight_ready;
    logic                               energy_valid;
    logic signed [ENERGY_TOTAL_BIT-1:0] energy;
    logic                               energy_ready;
    logic                               debug_en;
    logic                               accum_overflow;

    // current frame, row i holds the couplings of spin i
    logic signed [BITJ-1:0] wgt [DATASPIN][DATASPIN];
    logic signed [BITH-1:0] hb [DATASPIN];
    logic [SCALING_BIT-1:0] hsc [DATASPIN];

    logic [31:0] lfsr;
    int          gap_left;
    int          errors;
    int          checks;
    int          failed_tests;

    energy_monitor dut (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .en_i             (en),
        .config_valid_i   (config_valid),
        .config_counter_i (config_counter),
        .config_ready_o   (config_ready),
        .spin_valid_i     (spin_valid),
        .spin_i           (spin),
        .spin_ready_o     (spin_ready),
        .weight_valid_i   (weight_valid),
        .weight_i         (weight),
        .hbias_i          (hbias),
        .hscaling_i       (hscaling),
        .weight_ready_o   (weight_ready),
        .energy_valid_o   (energy_valid),
        .energy_o         (energy),
        .energy_ready_i   (energy_ready),
        .debug_en_i       (debug_en),
        .accum_overflow_o (accum_overflow)
    );

    bind energy_monitor energy_monitor_properties u_properties (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (en_i),
        .energy_valid_i (energy_valid_o),
        .energy_ready_i (energy_ready_i),
        .energy_i       (energy_o),
        .spin_open_i    (spin_ready_p),
        .rows_left_i    (counter_ready),
        .overflow_i     (accum_overflow_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // sum over rows of s_i * (sum_j J_ij * s_j + h_i * k_i)
    function automatic int model_energy(input int last, input logic [DATASPIN-1:0] s);
        int total;
        int field;
        total = 0;
        for (int i = 0; i <= last; i++) begin
            field = int'(hb[i]) * int'(hsc[i]);
            for (int j = 0; j < DATASPIN; j++) begin
                field += s[j] ? int'(wgt[i][j]) : -int'(wgt[i][j]);
            end
            total += s[i] ? field : -field;
        end
        return total;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // every drive happens here, right on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (gap_left > 0) begin
            en = 1'b0;
            gap_left--;
        end else begin
            en = 1'b1;
        end
    endtask

    function automatic logic ready_of(input int ch);
        case (ch)
            0:       return config_ready;
            1:       return spin_ready;
            default: return weight_ready;
        endcase
    endfunction

    // valid is already up, returns on the negedge after the transfer
    task automatic wait_accept(input int ch);
        #1;
        while (!ready_of(ch)) begin
            next_cycle();
            #1;
        end
        next_cycle();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic send_config(input logic [SPINIDX_BIT-1:0] last);
        next_cycle();
        config_valid = 1'b1;
        config_counter = last;
        wait_accept(0);
        config_valid = 1'b0;
    endtask

    task automatic run_frame(input test_t tc, output int exp);
        logic [31:0] bits;
        logic [31:0] held;
        int          last;
        last = int'(tc.last_idx);
        for (int r = 0; r <= last; r++) begin
            for (int j = 0; j < DATASPIN; j++) begin
                take_bits(BITJ, bits);
                wgt[r][j] = tc.max_w ? 4'h8 : bits[BITJ-1:0];
            end
            take_bits(BITH, bits);
            hb[r] = tc.max_w ? 4'h8 : bits[BITH-1:0];
            take_bits(SCALING_BIT, bits);
            hsc[r] = tc.max_w ? 5'h1f : bits[SCALING_BIT-1:0];
        end
        exp = model_energy(last, tc.spins);

        next_cycle();
        debug_en = tc.debug_en;
        spin_valid = 1'b1;
        spin = tc.spins;
        wait_accept(1);
        spin_valid = 1'b0;

        for (int r = 0; r <= last; r++) begin
            if (tc.en_gap && r == 6) gap_left = 5;
            for (int j = 0; j < DATASPIN; j++) begin
                weight[j*BITJ +: BITJ] = wgt[r][j];
            end
            hbias = hb[r];
            hscaling = hsc[r];
            weight_valid = 1'b1;
            wait_accept(2);
        end
        weight_valid = 1'b0;

        #1;
        while (!energy_valid) begin
            next_cycle();
            #1;
        end
        check("energy_o", energy, exp);
        check("accum_overflow_o", accum_overflow, 32'd0);
        check("weight_ready_p", dut.weight_ready_p, 32'd0); // frame closed
        held = energy;
        for (int k = 0; k < int'(tc.stall); k++) begin
            next_cycle();
            #1;
            check("energy_valid_o", energy_valid, 32'd1);
            check("energy_o", energy, held);
            check("spin_ready_p", dut.spin_ready_p, 32'd0);
        end
        next_cycle();
        energy_ready = 1'b1;
        #1;
        check("energy_valid_o", energy_valid, 32'd1);
        next_cycle();
        energy_ready = 1'b0;
        #1;
        check("energy_valid_o", energy_valid, 32'd0);
        check("energy_o", energy, 32'd0); // sum cleared by the accept
    endtask

    initial begin : watchdog
        int limit;
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += DATASPIN + int'(tests[t].stall) + 40;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int configured;
        int err_before;
        int expected;
        arst_n = 1'b0;
        en = 1'b1;
        config_valid = 1'b0;
        config_counter = '0;
        spin_valid = 1'b0;
        spin = '0;
        weight_valid = 1'b0;
        weight = '0;
        hbias = '0;
        hscaling = '0;
        energy_ready = 1'b0;
        debug_en = 1'b0;
        gap_left = 0;
        errors = 0;
        checks = 0;
        failed_tests = 0;
        lfsr = 32'd91738;
        configured = -1;
        apply_reset();

        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            // config is taken only in IDLE, a new last index needs a reset
            if (int'(tests[t].last_idx) != configured) begin
                if (configured >= 0) apply_reset();
                send_config(tests[t].last_idx);
                configured = int'(tests[t].last_idx);
            end
            run_frame(tests[t], expected);
            if (errors == err_before) begin
                $display("test %0d: last index %0d, energy %0d, ok", t, configured, expected);
            end else begin
                failed_tests++;
                $display("test %0d: last index %0d, %0d mismatches", t, configured,
                         errors - err_before);
            end
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, failed_tests, checks, errors, dut.u_properties.fail_count);
        if (errors == 0 && dut.u_properties.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/ising_pkg.sv
hw/bp_pipe.sv
hw/logic_ctrl.sv
hw/counter_ctrl.sv
hw/partial_energy_calc.sv
hw/accumulator.sv
hw/energy_monitor.sv
sim/energy_monitor_properties.sv
sim/tb_energy_monitor.sv
